/* hw/lcd_pkg.sv */
// Shared constants, LCD command bytes and FSM state types, imported by every LCD I2C block
package lcd_pkg;

    // Short simulation values. Hardware uses 500 ms power-up and 100 ms probe gap
    localparam int unsigned SCL_QUARTER       = 4;
    localparam int unsigned POWER_UP_CYCLES   = 200;
    localparam int unsigned PROBE_GAP_CYCLES  = 40;
    localparam int unsigned CMD_SETTLE_CYCLES = 100;

    localparam int ADDR_W = 7;
    localparam int DATA_W = 8;

    localparam logic [ADDR_W-1:0] SCAN_ADDR_0 = 7'h20;
    localparam logic [ADDR_W-1:0] SCAN_ADDR_1 = 7'h27;
    localparam logic [ADDR_W-1:0] SCAN_ADDR_2 = 7'h3F;

    // HD44780 4-bit init, first command in the top byte
    localparam int INIT_CMD_COUNT = 7;
    localparam logic [8*INIT_CMD_COUNT-1:0] INIT_CMDS =
        {8'h33, 8'h32, 8'h28, 8'h0C, 8'h06, 8'h01, 8'h80};
    localparam logic [DATA_W-1:0] LINE2_CMD = 8'hC0;

    localparam int LINE_LEN   = 16;
    localparam int PREFIX_LEN = 8;
    localparam logic [8*LINE_LEN-1:0]   LINE1_TEXT   = "Hello from FPGA!";
    localparam logic [8*PREFIX_LEN-1:0] LINE2_PREFIX = "Addr: 0x";

    // Byte order of the whole LCD stream
    localparam int LINE1_FIRST   = INIT_CMD_COUNT;
    localparam int LINE2_CMD_IDX = LINE1_FIRST + LINE_LEN;
    localparam int LINE2_FIRST   = LINE2_CMD_IDX + 1;
    localparam int SEQ_BYTES     = LINE2_FIRST + LINE_LEN;

    // Backpack bit map, RW at bit 1 stays low
    localparam int BL_BIT = 3;
    localparam int EN_BIT = 2;
    localparam int RS_BIT = 0;

    typedef enum logic [2:0] {
        I2C_IDLE,
        I2C_START,
        I2C_ADDR,
        I2C_ADDR_ACK,
        I2C_DATA,
        I2C_DATA_ACK,
        I2C_STOP
    } i2c_state_t;

    typedef enum logic [2:0] {
        SCAN_POWER_WAIT,
        SCAN_ISSUE,
        SCAN_WAIT,
        SCAN_GAP,
        SCAN_FOUND,
        SCAN_FAILED
    } scan_state_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_SEND,
        SEQ_SETTLE,
        SEQ_DONE
    } seq_state_t;

endpackage

/* hw/i2c_master.sv */
// Write-only I2C master, sends address plus one data byte per ena/busy request
`timescale 1ns/10ps

module i2c_master import lcd_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              ena,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] data_wr,
    output logic              busy,
    output logic              ack_error,
    inout  wire               sda,
    output logic              scl
);

    i2c_state_t        state;
    logic [15:0]       q_cnt;
    logic              tick;
    logic [1:0]        phase;   // Quarter within the current bit slot
    logic [2:0]        bit_cnt;
    logic [DATA_W-1:0] shift;
    logic [DATA_W-1:0] data_q;
    logic              sda_low;

    assign tick = (q_cnt == 16'(SCL_QUARTER - 1));
    assign sda  = sda_low ? 1'b0 : 1'bz;   // Open drain

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            q_cnt <= '0;
        end else if (tick) begin
            q_cnt <= '0;
        end else begin
            q_cnt <= q_cnt + 16'd1;
        end
    end

    // Frame is 20 bit slots of four quarters each:
    // start, 8 address bits, ack, 8 data bits, ack, stop
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= I2C_IDLE;
            phase     <= 2'd0;
            bit_cnt   <= 3'd7;
            shift     <= '0;
            data_q    <= '0;
            busy      <= 1'b0;
            ack_error <= 1'b0;
            scl       <= 1'b1;
            sda_low   <= 1'b0;
        end else if (tick) begin
            if (state != I2C_IDLE) begin
                phase <= phase + 2'd1;
            end
            case (state)
                I2C_IDLE: begin
                    if (ena) begin
                        busy   <= 1'b1;
                        shift  <= {addr, 1'b0};   // Write direction
                        data_q <= data_wr;
                        state  <= I2C_START;
                    end
                end
                I2C_START: begin
                    if (phase == 2'd2) begin
                        sda_low   <= 1'b1;   // SDA falls while SCL high
                        ack_error <= 1'b0;
                    end else if (phase == 2'd3) begin
                        scl   <= 1'b0;
                        state <= I2C_ADDR;
                    end
                end
                I2C_ADDR, I2C_DATA: begin
                    case (phase)
                        2'd0: sda_low <= ~shift[DATA_W-1];
                        2'd1: scl <= 1'b1;
                        2'd3: begin
                            scl     <= 1'b0;
                            shift   <= {shift[DATA_W-2:0], 1'b0};
                            bit_cnt <= bit_cnt - 3'd1;   // Wraps back to 7
                            if (bit_cnt == 3'd0) begin
                                state <= (state == I2C_ADDR) ? I2C_ADDR_ACK : I2C_DATA_ACK;
                            end
                        end
                        default: ;
                    endcase
                end
                I2C_ADDR_ACK, I2C_DATA_ACK: begin
                    case (phase)
                        2'd0: sda_low <= 1'b0;   // Slave owns SDA
                        2'd1: scl <= 1'b1;
                        2'd2: begin
                            if (state == I2C_ADDR_ACK) begin
                                ack_error <= sda;   // High means no device
                            end
                        end
                        2'd3: begin
                            scl <= 1'b0;
                            if (state == I2C_ADDR_ACK) begin
                                shift <= data_q;
                                state <= I2C_DATA;
                            end else begin
                                state <= I2C_STOP;
                            end
                        end
                    endcase
                end
                I2C_STOP: begin
                    case (phase)
                        2'd0: sda_low <= 1'b1;
                        2'd1: scl <= 1'b1;
                        2'd2: sda_low <= 1'b0;   // SDA rises while SCL high
                        2'd3: begin
                            busy  <= 1'b0;
                            state <= I2C_IDLE;
                        end
                    endcase
                end
                default: state <= I2C_IDLE;
            endcase
        end
    end

endmodule

/* hw/lcd_addr_scanner.sv */
// Waits after power-up, then probes the candidate backpack addresses until one acknowledges
`timescale 1ns/10ps

module lcd_addr_scanner import lcd_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              busy,
    input  logic              ack_error,
    output logic              ena,
    output logic [DATA_W-1:0] data,
    output logic [ADDR_W-1:0] lcd_addr,
    output logic              scan_done,
    output logic              addr_found
);

    scan_state_t state;
    logic [31:0] cnt;
    logic [1:0]  scan_idx;
    logic        busy_q;
    logic        xfer_done;

    function automatic logic [ADDR_W-1:0] scan_addr(input logic [1:0] idx);
        case (idx)
            2'd0:    return SCAN_ADDR_0;
            2'd1:    return SCAN_ADDR_1;
            default: return SCAN_ADDR_2;
        endcase
    endfunction

    assign xfer_done = busy_q & ~busy;
    assign data      = '0;   // Probe byte

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= SCAN_POWER_WAIT;
            cnt        <= '0;
            scan_idx   <= 2'd0;
            busy_q     <= 1'b0;
            ena        <= 1'b0;
            lcd_addr   <= SCAN_ADDR_0;
            scan_done  <= 1'b0;
            addr_found <= 1'b0;
        end else begin
            busy_q <= busy;
            case (state)
                SCAN_POWER_WAIT: begin
                    if (cnt == POWER_UP_CYCLES - 1) begin
                        cnt   <= '0;
                        state <= SCAN_ISSUE;
                    end else begin
                        cnt <= cnt + 32'd1;
                    end
                end
                SCAN_ISSUE: begin
                    if (!busy && !ena) begin
                        lcd_addr <= scan_addr(scan_idx);
                        ena      <= 1'b1;
                        state    <= SCAN_WAIT;
                    end
                end
                SCAN_WAIT: begin
                    if (busy) ena <= 1'b0;
                    if (xfer_done) state <= SCAN_GAP;
                end
                SCAN_GAP: begin
                    if (cnt == PROBE_GAP_CYCLES - 1) begin
                        cnt <= '0;
                        if (!ack_error) begin
                            addr_found <= 1'b1;
                            scan_done  <= 1'b1;
                            state      <= SCAN_FOUND;
                        end else if (scan_idx == 2'd2) begin
                            scan_done <= 1'b1;   // Nothing answered
                            state     <= SCAN_FAILED;
                        end else begin
                            scan_idx <= scan_idx + 2'd1;
                            state    <= SCAN_ISSUE;
                        end
                    end else begin
                        cnt <= cnt + 32'd1;
                    end
                end
                default: ;   // Found or failed, hold
            endcase
        end
    end

endmodule

/* hw/lcd_nibble_writer.sv */
// Splits one LCD byte into four backpack writes, pulsing EN for each nibble
`timescale 1ns/10ps

module lcd_nibble_writer import lcd_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              byte_start,
    input  logic              byte_rs,
    input  logic [DATA_W-1:0] byte_data,
    input  logic              busy,
    output logic              ena,
    output logic [DATA_W-1:0] data,
    output logic              byte_done
);

    logic [DATA_W-1:0] byte_q;
    logic              rs_q;
    logic [1:0]        step;   // High/EN, high, low/EN, low
    logic              active;
    logic              in_flight;
    logic              busy_q;

    function automatic logic [DATA_W-1:0] frame(input logic [3:0] nib,
                                                input logic en,
                                                input logic rs);
        logic [DATA_W-1:0] f;
        f         = '0;
        f[7:4]    = nib;
        f[BL_BIT] = 1'b1;   // Backlight always on
        f[EN_BIT] = en;
        f[RS_BIT] = rs;
        return f;
    endfunction

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            byte_q    <= '0;
            rs_q      <= 1'b0;
            step      <= 2'd0;
            active    <= 1'b0;
            in_flight <= 1'b0;
            busy_q    <= 1'b0;
            ena       <= 1'b0;
            data      <= '0;
            byte_done <= 1'b0;
        end else begin
            busy_q    <= busy;
            byte_done <= 1'b0;
            if (!active) begin
                if (byte_start) begin
                    byte_q <= byte_data;
                    rs_q   <= byte_rs;
                    step   <= 2'd0;
                    active <= 1'b1;
                end
            end else if (!in_flight) begin
                if (!busy && !ena) begin
                    data      <= frame(step[1] ? byte_q[3:0] : byte_q[7:4], ~step[0], rs_q);
                    ena       <= 1'b1;
                    in_flight <= 1'b1;
                end
            end else begin
                if (busy) ena <= 1'b0;
                if (busy_q && !busy) begin
                    in_flight <= 1'b0;
                    step      <= step + 2'd1;
                    if (step == 2'd3) begin
                        active    <= 1'b0;
                        byte_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hw/lcd_sequencer.sv */
// Feeds the init commands and the two message lines to the nibble writer, one byte at a time
`timescale 1ns/10ps

module lcd_sequencer import lcd_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              start,
    input  logic [ADDR_W-1:0] lcd_addr,
    input  logic              byte_done,
    output logic              byte_start,
    output logic              byte_rs,
    output logic [DATA_W-1:0] byte_data,
    output logic              lcd_done
);

    seq_state_t        state;
    logic [5:0]        idx;      // Position in the whole byte stream
    logic [5:0]        l2_pos;
    logic [31:0]       cnt;
    logic [DATA_W-1:0] next_byte;
    logic              next_rs;

    function automatic logic [7:0] hex_char(input logic [3:0] nib);
        return (nib < 4'd10) ? 8'h30 + {4'h0, nib} : 8'h37 + {4'h0, nib};
    endfunction

    assign l2_pos = idx - 6'(LINE2_FIRST);

    always_comb begin
        next_rs   = 1'b1;
        next_byte = 8'h20;   // Space padding
        if (idx < LINE1_FIRST) begin
            next_rs   = 1'b0;
            next_byte = INIT_CMDS[8*(INIT_CMD_COUNT-1-idx) +: 8];
        end else if (idx < LINE2_CMD_IDX) begin
            next_byte = LINE1_TEXT[8*(LINE2_CMD_IDX-1-idx) +: 8];
        end else if (idx == LINE2_CMD_IDX) begin
            next_rs   = 1'b0;
            next_byte = LINE2_CMD;
        end else if (l2_pos < PREFIX_LEN) begin
            next_byte = LINE2_PREFIX[8*(PREFIX_LEN-1-l2_pos) +: 8];
        end else if (l2_pos == PREFIX_LEN) begin
            next_byte = hex_char({1'b0, lcd_addr[6:4]});
        end else if (l2_pos == PREFIX_LEN + 1) begin
            next_byte = hex_char(lcd_addr[3:0]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= SEQ_IDLE;
            idx        <= '0;
            cnt        <= '0;
            byte_start <= 1'b0;
            byte_rs    <= 1'b0;
            byte_data  <= '0;
            lcd_done   <= 1'b0;
        end else begin
            byte_start <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (start) state <= SEQ_LOAD;
                end
                SEQ_LOAD: begin
                    byte_data  <= next_byte;
                    byte_rs    <= next_rs;
                    byte_start <= 1'b1;
                    state      <= SEQ_SEND;
                end
                SEQ_SEND: begin
                    if (byte_done) begin
                        if (idx < LINE1_FIRST) begin
                            state <= SEQ_SETTLE;   // Init commands need time
                        end else if (idx == SEQ_BYTES - 1) begin
                            lcd_done <= 1'b1;
                            state    <= SEQ_DONE;
                        end else begin
                            idx   <= idx + 6'd1;
                            state <= SEQ_LOAD;
                        end
                    end
                end
                SEQ_SETTLE: begin
                    if (cnt == CMD_SETTLE_CYCLES - 1) begin
                        cnt   <= '0;
                        idx   <= idx + 6'd1;
                        state <= SEQ_LOAD;
                    end else begin
                        cnt <= cnt + 32'd1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* hw/lcd_top.sv */
// LCD greeting top level, scans for the backpack and then drives the display over one I2C master
`timescale 1ns/10ps

module lcd_top import lcd_pkg::*; (
    input  logic              clk,
    input  logic              reset_n,
    inout  wire               sda,
    output logic              scl,
    output logic              scan_done,
    output logic              addr_found,
    output logic              lcd_done,
    output logic [ADDR_W-1:0] lcd_addr
);

    logic              busy;
    logic              ack_error;
    logic              m_ena;
    logic [DATA_W-1:0] m_data;
    logic              scan_ena;
    logic [DATA_W-1:0] scan_data;
    logic              nib_ena;
    logic [DATA_W-1:0] nib_data;
    logic              byte_start;
    logic              byte_rs;
    logic [DATA_W-1:0] byte_data;
    logic              byte_done;
    logic              seq_start;

    // Scanner owns the master until the scan ends
    assign m_ena     = scan_done ? nib_ena : scan_ena;
    assign m_data    = scan_done ? nib_data : scan_data;
    assign seq_start = scan_done & addr_found;

    i2c_master i2c0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .ena       (m_ena),
        .addr      (lcd_addr),
        .data_wr   (m_data),
        .busy      (busy),
        .ack_error (ack_error),
        .sda       (sda),
        .scl       (scl)
    );

    lcd_addr_scanner scan0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .busy       (busy),
        .ack_error  (ack_error),
        .ena        (scan_ena),
        .data       (scan_data),
        .lcd_addr   (lcd_addr),
        .scan_done  (scan_done),
        .addr_found (addr_found)
    );

    lcd_nibble_writer nib0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .byte_start (byte_start),
        .byte_rs    (byte_rs),
        .byte_data  (byte_data),
        .busy       (busy),
        .ena        (nib_ena),
        .data       (nib_data),
        .byte_done  (byte_done)
    );

    lcd_sequencer seq0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (seq_start),
        .lcd_addr   (lcd_addr),
        .byte_done  (byte_done),
        .byte_start (byte_start),
        .byte_rs    (byte_rs),
        .byte_data  (byte_data),
        .lcd_done   (lcd_done)
    );

endmodule

/* tb/i2c_slave_model.sv */
// I2C slave bus model for the testbench, acknowledges one address and logs probes and data bytes
`timescale 1ns/10ps

module i2c_slave_model (
    input  logic       clk,
    input  logic       reset_n,
    input  logic [6:0] dev_addr,
    input  logic       scl,
    inout  wire        sda
);

    logic [6:0] addr_log [0:15];    // Every address seen after a start
    logic [7:0] data_log [0:255];   // Acknowledged data bytes only
    int         addr_cnt;
    int         data_cnt;
    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       in_addr;
    logic       matched;
    logic       ack_drive;
    logic [3:0] bit_cnt;
    logic [7:0] shift;

    assign sda = ack_drive ? 1'b0 : 1'bz;

    // Oversampled by the system clock, SCL holds for a whole quarter period
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_cnt  <= 0;
            data_cnt  <= 0;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            active    <= 1'b0;
            in_addr   <= 1'b0;
            matched   <= 1'b0;
            ack_drive <= 1'b0;
            bit_cnt   <= 4'd0;
            shift     <= '0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin   // Start
                active  <= 1'b1;
                in_addr <= 1'b1;
                bit_cnt <= 4'd0;
            end else if (scl && scl_q && !sda_q && sda) begin   // Stop
                active <= 1'b0;
            end else if (active && scl && !scl_q) begin
                if (bit_cnt < 4'd8) begin
                    shift   <= {shift[6:0], sda};
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (active && !scl && scl_q) begin
                if (bit_cnt == 4'd8) begin
                    bit_cnt <= 4'd9;   // Ack slot follows
                    if (in_addr) begin
                        if (addr_cnt < 16) addr_log[addr_cnt] <= shift[7:1];
                        addr_cnt  <= addr_cnt + 1;
                        matched   <= (shift[7:1] == dev_addr) && !shift[0];
                        ack_drive <= (shift[7:1] == dev_addr) && !shift[0];
                    end else if (matched) begin
                        if (data_cnt < 256) data_log[data_cnt] <= shift;
                        data_cnt  <= data_cnt + 1;
                        ack_drive <= 1'b1;
                    end
                end else if (bit_cnt == 4'd9) begin
                    ack_drive <= 1'b0;
                    in_addr   <= 1'b0;
                    bit_cnt   <= 4'd0;
                end
            end
        end
    end

endmodule

/* tb/tb_lcd_top.sv */
// Testbench for the LCD greeting top level, directed scan and message tests against a slave model
`timescale 1ns/10ps

module tb_lcd_top;

    logic        clk;
    logic        reset_n;
    logic [6:0]  dev_addr;
    wire         sda;
    logic        scl;
    logic        scan_done;
    logic        addr_found;
    logic        lcd_done;
    logic [6:0]  lcd_addr;
    logic [31:0] lfsr;
    logic [7:0]  exp_byte [0:39];
    logic        exp_rs [0:39];
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_bad;

    pullup (sda);

    lcd_top dut0 (
        .clk        (clk),
        .reset_n    (reset_n),
        .sda        (sda),
        .scl        (scl),
        .scan_done  (scan_done),
        .addr_found (addr_found),
        .lcd_done   (lcd_done),
        .lcd_addr   (lcd_addr)
    );

    i2c_slave_model model0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .dev_addr (dev_addr),
        .scl      (scl),
        .sda      (sda)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32, 22, 2, 1
    endfunction

    function automatic logic [7:0] hex_ascii(input logic [3:0] n);
        return (n < 4'd10) ? 8'h30 + 8'(n) : 8'h41 + 8'(n) - 8'd10;
    endfunction

    // Nibble on top, then BL, EN, RW low, RS
    function automatic logic [7:0] backpack_byte(input logic [3:0] nib,
                                                 input logic en,
                                                 input logic rs);
        return {nib, 1'b1, en, 1'b0, rs};
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("** Error at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, want);
            test_errors++;
        end
    endtask

    task automatic reset_dut(input logic [6:0] addr);
        @(posedge clk);
        reset_n  <= 1'b0;
        dev_addr <= addr;
        repeat (10) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    // which 0 is scan_done, 1 is lcd_done
    task automatic wait_high(input int which, input int limit, output bit seen);
        seen = 1'b0;
        for (int n = 0; n < limit && !seen; n++) begin
            @(negedge clk);
            seen = (which == 0) ? scan_done : lcd_done;
        end
    endtask

    task automatic build_expected(input logic [6:0] addr);
        logic [7:0] init_cmds [0:6];
        string      line1;
        string      prefix;
        init_cmds = '{8'h33, 8'h32, 8'h28, 8'h0C, 8'h06, 8'h01, 8'h80};
        line1     = "Hello from FPGA!";
        prefix    = "Addr: 0x";
        for (int i = 0; i < 7; i++) begin
            exp_byte[i] = init_cmds[i];
            exp_rs[i]   = 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            exp_byte[7 + i] = line1[i];
            exp_rs[7 + i]   = 1'b1;
        end
        exp_byte[23] = 8'hC0;
        exp_rs[23]   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            exp_rs[24 + i] = 1'b1;
            if (i < 8) exp_byte[24 + i] = prefix[i];
            else if (i == 8) exp_byte[24 + i] = hex_ascii({1'b0, addr[6:4]});
            else if (i == 9) exp_byte[24 + i] = hex_ascii(addr[3:0]);
            else exp_byte[24 + i] = 8'h20;
        end
    endtask

    task automatic check_lcd_byte(input int k);
        logic [7:0] want [0:3];
        int         base;
        base    = 1 + 4 * k;   // Log slot 0 is the probe byte
        want[0] = backpack_byte(exp_byte[k][7:4], 1'b1, exp_rs[k]);
        want[1] = backpack_byte(exp_byte[k][7:4], 1'b0, exp_rs[k]);
        want[2] = backpack_byte(exp_byte[k][3:0], 1'b1, exp_rs[k]);
        want[3] = backpack_byte(exp_byte[k][3:0], 1'b0, exp_rs[k]);
        for (int j = 0; j < 4; j++) begin
            if (base + j >= model0.data_cnt) begin
                $display("I2C write %0d for LCD byte %0d never arrived", base + j, k);
                test_errors++;
            end else if (model0.data_log[base + j] !== want[j]) begin
                $display("** Error at %0t: model0.data_log[%0d] got 0x%02h expected 0x%02h",
                         $time, base + j, model0.data_log[base + j], want[j]);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: FAILED with %0d errors", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // Whole greeting from reset to lcd_done
    task automatic run_greeting(input logic [6:0] addr);
        bit seen;
        reset_dut(addr);
        build_expected(addr);
        wait_high(1, 120000, seen);
        if (!seen) begin
            $display("lcd_done did not rise within 120000 cycles");
            test_errors++;
        end
        expect_eq("model0.data_cnt", model0.data_cnt, 161);
        expect_eq("model0.data_log[0]", model0.data_log[0], 8'h00);
    endtask

    task automatic test_scan_found();
        bit seen;
        reset_dut(7'h27);
        wait_high(0, 5000, seen);
        if (!seen) begin
            $display("scan_done did not rise within 5000 cycles");
            test_errors++;
        end
        if (model0.addr_cnt < 2) begin
            $display("Fewer than two probe addresses seen on the bus");
            test_errors++;
        end
        expect_eq("addr_found", addr_found, 1'b1);
        expect_eq("lcd_addr", lcd_addr, 7'h27);
        expect_eq("model0.addr_log[0]", model0.addr_log[0], 7'h20);
        expect_eq("model0.addr_log[1]", model0.addr_log[1], 7'h27);
        finish_test("scan with device at 0x27");
    endtask

    task automatic test_no_device();
        bit seen;
        reset_dut(7'h50);   // Nothing at any probed address
        wait_high(0, 5000, seen);
        if (!seen) begin
            $display("scan_done did not rise within 5000 cycles");
            test_errors++;
        end
        expect_eq("addr_found", addr_found, 1'b0);
        wait_high(1, 20000, seen);
        if (seen) begin
            $display("lcd_done rose with no device on the bus");
            test_errors++;
        end
        expect_eq("model0.addr_cnt", model0.addr_cnt, 3);
        expect_eq("model0.addr_log[0]", model0.addr_log[0], 7'h20);
        expect_eq("model0.addr_log[1]", model0.addr_log[1], 7'h27);
        expect_eq("model0.addr_log[2]", model0.addr_log[2], 7'h3F);
        expect_eq("model0.data_cnt", model0.data_cnt, 0);
        finish_test("scan with no device");
    endtask

    task automatic test_init_commands();
        run_greeting(7'h27);
        for (int k = 0; k < 7; k++) check_lcd_byte(k);
        finish_test("init commands");
    endtask

    task automatic test_message();
        run_greeting(7'h27);
        for (int k = 7; k < 40; k++) check_lcd_byte(k);
        finish_test("message for 0x27");
    endtask

    task automatic test_other_address();
        logic [6:0] addr;
        lfsr = lfsr_next(lfsr);
        addr = lfsr[0] ? 7'h3F : 7'h20;
        run_greeting(addr);
        expect_eq("lcd_addr", lcd_addr, addr);
        check_lcd_byte(32);   // Hex digits of line 2
        check_lcd_byte(33);
        finish_test($sformatf("message for 0x%02h", addr));
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        dev_addr    = 7'h00;
        lfsr        = 32'ha0b2;
        errors      = 0;
        test_errors = 0;
        tests_run   = 0;
        tests_bad   = 0;
        test_scan_found();
        test_no_device();
        test_init_commands();
        test_message();
        test_other_address();
        $display("%0d tests run, %0d with errors, %0d errors in total",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* list.f */
hw/lcd_pkg.sv
hw/i2c_master.sv
hw/lcd_addr_scanner.sv
hw/lcd_nibble_writer.sv
hw/lcd_sequencer.sv
hw/lcd_top.sv
tb/i2c_slave_model.sv
tb/tb_lcd_top.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Wno-fatal -j 0
TOP       := tb_lcd_top
FLIST     := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := tests failed

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
